// File: logic/core_pkg.sv
/*
 * Shared types for the reduced RV64I integer pipeline.
 * Only OP, OP-IMM and LUI are decoded; everything else retires
 * without a register write. The stage records are packed structs
 * so a whole slot moves through a register in one assignment.
 */

package core_pkg;

    localparam int XLEN       = 64;
    localparam int REG_ADDR_W = 5;

    typedef logic [31:0] insn_t;

    // major opcodes that are kept
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_t;

    // where an execute-stage source operand comes from
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_EXWB,
        FWD_WBFW
    } fwd_sel_t;

    typedef struct packed {
        logic                  valid;
        alu_op_t               alu_op;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic                  we;
        logic                  use_imm;
        logic                  zero_a;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic [XLEN-1:0]       imm;
    } id_ex_t;

    // retirement / register write record
    typedef struct packed {
        logic                  valid;
        logic                  we;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_t;

endpackage

// File: logic/alu.sv
/*
 * Combinational 64-bit integer ALU.
 * Shift amounts use the low 6 bits of b_i (RV64 rules).
 * slt and sltu return 0 or 1; pass_b forwards b_i for LUI.
 */

`timescale 1ns/1ps

module alu import core_pkg::*; (
    input  logic [XLEN-1:0] a_i,
    input  logic [XLEN-1:0] b_i,
    input  alu_op_t         op_i,
    output logic [XLEN-1:0] y_o
);

    logic [5:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b_i[5:0];
    assign lt_s  = $signed(a_i) < $signed(b_i);
    assign lt_u  = a_i < b_i;

    always_comb begin
        case (op_i)
            ALU_ADD:  y_o = a_i + b_i;
            ALU_SUB:  y_o = a_i - b_i;
            ALU_SLL:  y_o = a_i << shamt;
            ALU_SLT:  y_o = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: y_o = {{(XLEN-1){1'b0}}, lt_u};
            ALU_XOR:  y_o = a_i ^ b_i;
            ALU_SRL:  y_o = a_i >> shamt;
            ALU_SRA:  y_o = $unsigned($signed(a_i) >>> shamt);
            ALU_OR:   y_o = a_i | b_i;
            ALU_AND:  y_o = a_i & b_i;
            default:  y_o = b_i;
        endcase
    end

endmodule

// File: logic/regfile.sv
/*
 * 32 x 64-bit integer register file, x0 hardwired to zero.
 * Reads are combinational; the write lands at the clock edge
 * and only while the pipeline advances.
 */

`timescale 1ns/1ps

module regfile import core_pkg::*; (
    input  logic                  c_clk,
    input  logic                  c_rst_n,
    input  logic                  adv_i,
    input  logic [REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [REG_ADDR_W-1:0] rs2_addr_i,
    output logic [XLEN-1:0]       rs1_data_o,
    output logic [XLEN-1:0]       rs2_data_o,
    input  wb_t                   wr_i
);

    // architectural state starts at zero
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge c_clk or negedge c_rst_n) begin
        if (!c_rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (adv_i && wr_i.valid && wr_i.we && (wr_i.rd != '0)) begin
            regs[wr_i.rd] <= wr_i.data;
        end
    end

    always_comb begin
        rs1_data_o = '0;
        rs2_data_o = '0;
        if (rs1_addr_i != '0) begin
            rs1_data_o = regs[rs1_addr_i];
        end
        if (rs2_addr_i != '0) begin
            rs2_data_o = regs[rs2_addr_i];
        end
    end

endmodule

// File: logic/hazard_ctrl.sv
/*
 * Pipeline control. A single global stall freezes every stage, so
 * advance and input ready are both its inverse.
 * Forwarding compares the execute-stage sources against the
 * execute/writeback record first, then the forward register.
 */

`timescale 1ns/1ps

module hazard_ctrl import core_pkg::*; (
    input  logic     stall_i,
    input  id_ex_t   id_ex_i,
    input  wb_t      ex_wb_i,
    input  wb_t      wb_fw_i,
    output logic     adv_o,
    output logic     ins_ready_o,
    output fwd_sel_t fwd_a_o,
    output fwd_sel_t fwd_b_o
);

    // newer record wins; x0 never forwards
    function automatic fwd_sel_t pick_src(input logic [REG_ADDR_W-1:0] rs,
                                          input wb_t newer,
                                          input wb_t older);
        fwd_sel_t sel;
        sel = FWD_REG;
        if (rs != '0) begin
            if (newer.valid && newer.we && (newer.rd == rs)) begin
                sel = FWD_EXWB;
            end else if (older.valid && older.we && (older.rd == rs)) begin
                sel = FWD_WBFW;
            end
        end
        return sel;
    endfunction

    assign adv_o       = !stall_i;
    assign ins_ready_o = !stall_i;

    assign fwd_a_o = pick_src(id_ex_i.rs1, ex_wb_i, wb_fw_i);
    assign fwd_b_o = pick_src(id_ex_i.rs2, ex_wb_i, wb_fw_i);

endmodule

// File: logic/decode_stage.sv
/*
 * Decode stage. Register reads are combinational from ins_i, so the
 * values captured here miss a write landing at the same edge; the
 * execute stage covers that through forwarding.
 * Unknown opcodes decode to pass_b of a zero immediate with we low.
 */

`timescale 1ns/1ps

module decode_stage import core_pkg::*; (
    input  logic                  c_clk,
    input  logic                  c_rst_n,
    input  logic                  adv_i,
    input  logic                  ins_valid_i,
    input  insn_t                 ins_i,
    output logic [REG_ADDR_W-1:0] rs1_addr_o,
    output logic [REG_ADDR_W-1:0] rs2_addr_o,
    input  logic [XLEN-1:0]       rs1_data_i,
    input  logic [XLEN-1:0]       rs2_data_i,
    output id_ex_t                id_ex_o
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;
    logic            legal;
    id_ex_t          dec;

    // bit 30 picks sub for add and arithmetic for right shifts
    function automatic alu_op_t map_alu(input logic [2:0] f3, input logic alt);
        alu_op_t op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode     = ins_i[6:0];
    assign funct3     = ins_i[14:12];
    assign rs1_addr_o = ins_i[19:15];
    assign rs2_addr_o = ins_i[24:20];

    assign imm_i = {{(XLEN-12){ins_i[31]}}, ins_i[31:20]};
    assign imm_u = {{(XLEN-32){ins_i[31]}}, ins_i[31:12], 12'b0};

    always_comb begin
        dec          = '0;
        dec.valid    = ins_valid_i;
        dec.rs1      = ins_i[19:15];
        dec.rs2      = ins_i[24:20];
        dec.rd       = ins_i[11:7];
        dec.rs1_data = rs1_data_i;
        dec.rs2_data = rs2_data_i;
        dec.alu_op   = ALU_PASS_B;
        dec.use_imm  = 1'b1;
        legal        = 1'b1;
        case (opcode)
            OPC_OP: begin
                dec.use_imm = 1'b0;
                dec.alu_op  = map_alu(funct3, ins_i[30]);
            end
            OPC_OP_IMM: begin
                // no subi, so bit 30 only matters for srai
                dec.imm    = imm_i;
                dec.alu_op = map_alu(funct3, ins_i[30] && (funct3 == 3'b101));
            end
            OPC_LUI: begin
                dec.imm    = imm_u;
                dec.zero_a = 1'b1;
            end
            default: legal = 1'b0;
        endcase
        dec.we = legal && (dec.rd != '0);
    end

    always_ff @(posedge c_clk or negedge c_rst_n) begin
        if (!c_rst_n) begin
            id_ex_o <= '0;
        end else if (adv_i) begin
            id_ex_o <= dec;
        end
    end

endmodule

// File: logic/execute_stage.sv
/*
 * Execute stage: operand forwarding muxes, the ALU, the
 * execute/writeback register and the writeback forward register.
 * The forward register keeps the last writing record so an
 * instruction two slots younger still sees its value.
 */

`timescale 1ns/1ps

module execute_stage import core_pkg::*; (
    input  logic     c_clk,
    input  logic     c_rst_n,
    input  logic     adv_i,
    input  id_ex_t   id_ex_i,
    input  fwd_sel_t fwd_a_i,
    input  fwd_sel_t fwd_b_i,
    output wb_t      ex_wb_o,
    output wb_t      wb_fw_o
);

    logic [XLEN-1:0] src_a;
    logic [XLEN-1:0] src_b;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_y;

    function automatic logic [XLEN-1:0] fwd_mux(input fwd_sel_t sel,
                                                input logic [XLEN-1:0] reg_val,
                                                input logic [XLEN-1:0] exwb_val,
                                                input logic [XLEN-1:0] wbfw_val);
        logic [XLEN-1:0] v;
        case (sel)
            FWD_EXWB: v = exwb_val;
            FWD_WBFW: v = wbfw_val;
            default:  v = reg_val;
        endcase
        return v;
    endfunction

    assign src_a = fwd_mux(fwd_a_i, id_ex_i.rs1_data, ex_wb_o.data, wb_fw_o.data);
    assign src_b = fwd_mux(fwd_b_i, id_ex_i.rs2_data, ex_wb_o.data, wb_fw_o.data);

    // lui zeroes A, immediates replace B
    assign op_a = id_ex_i.zero_a ? '0 : src_a;
    assign op_b = id_ex_i.use_imm ? id_ex_i.imm : src_b;

    alu alu_inst (
        .a_i  (op_a),
        .b_i  (op_b),
        .op_i (id_ex_i.alu_op),
        .y_o  (alu_y)
    );

    always_ff @(posedge c_clk or negedge c_rst_n) begin
        if (!c_rst_n) begin
            ex_wb_o <= '0;
            wb_fw_o <= '0;
        end else if (adv_i) begin
            ex_wb_o.valid <= id_ex_i.valid;
            ex_wb_o.we    <= id_ex_i.valid && id_ex_i.we;
            ex_wb_o.rd    <= id_ex_i.rd;
            ex_wb_o.data  <= alu_y;
            if (ex_wb_o.valid && ex_wb_o.we) begin
                wb_fw_o <= ex_wb_o;
            end
        end
    end

endmodule

// File: logic/int_pipe.sv
/*
 * Reduced RV64I integer pipeline: decode, execute, writeback.
 * Accepts one instruction per cycle on valid/ready; ready drops
 * while stall_i is high and the whole pipeline holds.
 * ret_o shows each instruction two cycles after acceptance; its
 * register write lands at the next edge with stall_i low.
 */

`timescale 1ns/1ps

module int_pipe import core_pkg::*; (
    input  logic  c_clk,
    input  logic  c_rst_n,
    input  logic  ins_valid_i,
    input  insn_t ins_i,
    output logic  ins_ready_o,
    input  logic  stall_i,
    output wb_t   ret_o
);

    logic                  adv;
    fwd_sel_t              fwd_a;
    fwd_sel_t              fwd_b;
    id_ex_t                id_ex;
    wb_t                   ex_wb;
    wb_t                   wb_fw;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;

    assign ret_o = ex_wb;

    hazard_ctrl hazard_ctrl_inst (
        .stall_i     (stall_i),
        .id_ex_i     (id_ex),
        .ex_wb_i     (ex_wb),
        .wb_fw_i     (wb_fw),
        .adv_o       (adv),
        .ins_ready_o (ins_ready_o),
        .fwd_a_o     (fwd_a),
        .fwd_b_o     (fwd_b)
    );

    decode_stage decode_stage_inst (
        .c_clk       (c_clk),
        .c_rst_n     (c_rst_n),
        .adv_i       (adv),
        .ins_valid_i (ins_valid_i),
        .ins_i       (ins_i),
        .rs1_addr_o  (rs1_addr),
        .rs2_addr_o  (rs2_addr),
        .rs1_data_i  (rs1_data),
        .rs2_data_i  (rs2_data),
        .id_ex_o     (id_ex)
    );

    regfile regfile_inst (
        .c_clk      (c_clk),
        .c_rst_n    (c_rst_n),
        .adv_i      (adv),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wr_i       (ex_wb)
    );

    execute_stage execute_stage_inst (
        .c_clk   (c_clk),
        .c_rst_n (c_rst_n),
        .adv_i   (adv),
        .id_ex_i (id_ex),
        .fwd_a_i (fwd_a),
        .fwd_b_i (fwd_b),
        .ex_wb_o (ex_wb),
        .wb_fw_o (wb_fw)
    );

endmodule

// File: testbench/int_pipe_props.sv
/*
 * Concurrent checks on the int_pipe ports, bound into the DUT.
 * Stability of ret_o is checked one edge after each stalled edge.
 * Only reset behavior is checked while c_rst_n is low.
 */

`timescale 1ns/1ps

module int_pipe_props import core_pkg::*; (
    input logic c_clk,
    input logic c_rst_n,
    input logic ready_i,
    input logic stall_i,
    input wb_t  ret_i
);

    // ready is the inverse of the global stall
    ready_tracks_stall: assert property (
        @(posedge c_clk) disable iff (!c_rst_n) ready_i == !stall_i
    ) else $error("ins_ready_o differs from the inverse of stall_i");

    // a stalled edge leaves the retirement record alone
    ret_holds_on_stall: assert property (
        @(posedge c_clk) disable iff (!c_rst_n) stall_i |=> $stable(ret_i)
    ) else $error("ret_o changed across a stalled edge");

    no_retire_in_reset: assert property (
        @(posedge c_clk) !c_rst_n |-> !ret_i.valid
    ) else $error("ret_o.valid is high during reset");

endmodule

// File: testbench/int_pipe_tb.sv
/*
 * Testbench for int_pipe. Tests and expected retirements are read from
 * testbench/int_pipe_tests.txt, with the path relative to the project root.
 * Inputs change on the falling edge and outputs are sampled a quarter
 * period later. Stalls and input gaps come from an xorshift generator.
 * rd and data are compared only for instructions expected to write.
 */

`timescale 1ns/1ps

module int_pipe_tb import core_pkg::*; ();

    localparam int HALF_PERIOD  = 20;
    localparam int QUARTER      = 10;
    localparam int MAX_TESTS    = 64;
    localparam int WAIT_LIMIT   = 200;
    localparam int DRAIN_CYCLES = 4;

    // addi x1, x0, 0x7ff
    localparam logic [31:0] RESET_INSN = 32'h7ff00093;

    logic  c_clk;
    logic  c_rst_n;
    logic  ins_valid_i;
    insn_t ins_i;
    logic  ins_ready_o;
    logic  stall_i;
    wb_t   ret_o;

    // four words per test for insn, we, rd and data
    logic [63:0] vec_mem [0:MAX_TESTS*4-1];
    int          num_tests;
    int          errors;
    int          passed;
    int          failed;

    int_pipe int_pipe_inst (
        .c_clk       (c_clk),
        .c_rst_n     (c_rst_n),
        .ins_valid_i (ins_valid_i),
        .ins_i       (ins_i),
        .ins_ready_o (ins_ready_o),
        .stall_i     (stall_i),
        .ret_o       (ret_o)
    );

    bind int_pipe int_pipe_props int_pipe_props_inst (
        .c_clk   (c_clk),
        .c_rst_n (c_rst_n),
        .ready_i (ins_ready_o),
        .stall_i (stall_i),
        .ret_i   (ret_o)
    );

    initial begin
        c_clk = 1'b0;
        forever begin
            #(HALF_PERIOD) c_clk = ~c_clk;
        end
    end

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic load_tests();
        for (int i = 0; i < MAX_TESTS * 4; i++) begin
            vec_mem[i] = '1;
        end
        $readmemh("testbench/int_pipe_tests.txt", vec_mem);
        num_tests = 0;
        // an all-ones word cannot be an instruction and ends the list
        while (num_tests < MAX_TESTS && vec_mem[num_tests * 4] != '1) begin
            num_tests++;
        end
    endtask

    task automatic check_retirement(input int idx);
        logic                  exp_we;
        logic [REG_ADDR_W-1:0] exp_rd;
        logic [XLEN-1:0]       exp_data;
        int                    bad;
        exp_we   = vec_mem[idx * 4 + 1][0];
        exp_rd   = vec_mem[idx * 4 + 2][REG_ADDR_W-1:0];
        exp_data = vec_mem[idx * 4 + 3];
        bad      = 0;
        if (ret_o.we != exp_we) begin
            $display("FAILED test %0d ret_o.we: got %h, expected %h", idx, ret_o.we, exp_we);
            bad++;
        end
        if (exp_we && ret_o.rd != exp_rd) begin
            $display("FAILED test %0d ret_o.rd: got %h, expected %h", idx, ret_o.rd, exp_rd);
            bad++;
        end
        if (exp_we && ret_o.data != exp_data) begin
            $display("FAILED test %0d ret_o.data: got %h, expected %h",
                     idx, ret_o.data, exp_data);
            bad++;
        end
        if (bad == 0) begin
            passed++;
            $display("test %0d insn %h: ok", idx, vec_mem[idx * 4][31:0]);
        end else begin
            failed++;
            errors += bad;
            $display("test %0d insn %h: mismatch", idx, vec_mem[idx * 4][31:0]);
        end
    endtask

    initial begin : stimulus
        logic [31:0] rnd;
        int          next_in;
        int          next_out;
        int          idle;
        logic        taken;
        logic        was_stalled;
        wb_t         held_ret;

        // offered during reset and never taken, so x1 stays zero
        c_rst_n     = 1'b0;
        ins_valid_i = 1'b1;
        ins_i       = RESET_INSN;
        stall_i     = 1'b0;
        errors      = 0;
        passed      = 0;
        failed      = 0;
        rnd         = 32'd47;
        next_in     = 0;
        next_out    = 0;
        idle        = 0;
        taken       = 1'b0;
        was_stalled = 1'b0;
        held_ret    = '0;
        load_tests();
        if (num_tests == 0) begin
            $display("no tests were read from the data file");
            errors++;
        end

        repeat (5) begin
            @(posedge c_clk);
            #(QUARTER);
            if (ret_o.valid) begin
                $display("retirement record is valid during reset");
                errors++;
            end
        end
        @(negedge c_clk);
        c_rst_n     = 1'b1;
        ins_valid_i = 1'b0;
        ins_i       = '0;

        while (next_out < num_tests && idle < WAIT_LIMIT) begin
            @(negedge c_clk);
            if (taken) begin
                ins_valid_i = 1'b0;
                ins_i       = '0;
            end
            rnd     = next_random(rnd);
            stall_i = (rnd[1:0] == 2'd0);
            // a refused instruction stays on the port until it is taken
            if (!ins_valid_i && next_in < num_tests && rnd[4:3] != 2'd0) begin
                ins_valid_i = 1'b1;
                ins_i       = vec_mem[next_in * 4][31:0];
            end
            #(QUARTER);
            if (was_stalled && ret_o != held_ret) begin
                $display("ret_o changed across a stalled clock edge");
                errors++;
            end
            taken = ins_valid_i && ins_ready_o;
            if (taken) begin
                next_in++;
            end
            if (ret_o.valid && !stall_i) begin
                check_retirement(next_out);
                next_out++;
                idle = 0;
            end else begin
                idle++;
            end
            was_stalled = stall_i;
            held_ret    = ret_o;
        end

        if (idle >= WAIT_LIMIT) begin
            $display("timed out waiting for retirement of test %0d", next_out);
            errors++;
        end else begin
            // only bubbles may come out of an empty pipeline
            repeat (DRAIN_CYCLES) begin
                @(negedge c_clk);
                stall_i     = 1'b0;
                ins_valid_i = 1'b0;
                ins_i       = '0;
                #(QUARTER);
                if (ret_o.valid) begin
                    $display("extra retirement appeared after the last test");
                    errors++;
                end
            end
        end

        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 num_tests, passed, failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: testbench/int_pipe_tests.txt
// columns: instruction, expected we, expected rd, expected data (all hex)
// registers start at zero; rd and data matter only where we is 1
12308113 1 02 0000000000000123 // addi x2, x1, 0x123
fff00193 1 03 ffffffffffffffff // addi x3, x0, -1
e0010213 1 04 ffffffffffffff23 // addi x4, x2, -512
0f024293 1 05 ffffffffffffffd3 // xori x5, x4, 0xf0
fff13313 1 06 0000000000000001 // sltiu x6, x2, -1
03f19393 1 07 8000000000000000 // slli x7, x3, 63
43e3d413 1 08 fffffffffffffffe // srai x8, x7, 62
03c3d493 1 09 0000000000000008 // srli x9, x7, 60
80000537 1 0a ffffffff80000000 // lui x10, 0x80000
123455b7 1 0b 0000000012345000 // lui x11, 0x12345
00a58633 1 0c ffffffff92345000 // add x12, x11, x10
409006b3 1 0d fffffffffffffff8 // sub x13, x0, x9
00949733 1 0e 0000000000000800 // sll x14, x9, x9
0096a7b3 1 0f 0000000000000001 // slt x15, x13, x9
0096b833 1 10 0000000000000000 // sltu x16, x13, x9
00a648b3 1 11 0000000012345000 // xor x17, x12, x10
00955933 1 12 00ffffffff800000 // srl x18, x10, x9
409559b3 1 13 ffffffffff800000 // sra x19, x10, x9
00e4ea33 1 14 0000000000000808 // or x20, x9, x14
00527ab3 1 15 ffffffffffffff03 // and x21, x4, x5
00700b13 1 16 0000000000000007 // addi x22, x0, 7
001b0b13 1 16 0000000000000008 // addi x22, x22, 1
016b0bb3 1 17 0000000000000010 // add x23, x22, x22
416b8c33 1 18 0000000000000008 // sub x24, x23, x22
018b0cb3 1 19 0000000000000010 // add x25, x22, x24
00510013 0 00 0000000000000000 // addi x0, x2, 5
00e00eb3 1 1d 0000000000000800 // add x29, x0, x14
12345f0b 0 1e 0000000000000000 // custom-0 opcode, no write
000f0e33 1 1c 0000000000000000 // add x28, x30, x0

// File: compile.f
logic/core_pkg.sv
logic/alu.sv
logic/regfile.sv
logic/hazard_ctrl.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/int_pipe.sv
testbench/int_pipe_props.sv
testbench/int_pipe_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds int_pipe_tb with Verilator, runs it from the project root and checks sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -f compile.f --top-module int_pipe_tb \
    -Mdir obj_dir -o int_pipe_sim > build.log 2>&1 \
    && ./obj_dir/int_pipe_sim > sim.log 2>&1 \
    && ! grep -q "Simulation finished: FAIL" sim.log \
    && grep -q "Simulation finished: PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
